/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_calc_top
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing -Wno-fatal
SIM_FLAGS  := --binary --timing -Wno-fatal
PASS_MSG   := SIMULATION PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/calc_ref.svh */
//--------------------
// Calc reference model
// Expected results from the operation rules and
// the register state in program order
//--------------------

`ifndef CALC_REF_SVH
`define CALC_REF_SVH

typedef logic [`CALC_XLEN-1:0]   data_t;
typedef logic [`CALC_REG_AW-1:0] reg_addr_t;

typedef struct packed
{
  int unsigned cycle;
  reg_addr_t   rd_addr;
  data_t       rd_data;
} wb_expect_s;

// Updated only by instructions that survive
data_t      arch_regs [2**`CALC_REG_AW];
wb_expect_s expect_q [$];

function automatic data_t expected_result
  (
    input calc_pkg::calc_op_e op,
    input data_t              a,
    input data_t              b
  );
  logic [4:0]              shamt;
  logic [2*`CALC_XLEN-1:0] wide;
  shamt = b[4:0];
  wide  = {{`CALC_XLEN{1'b0}}, a} * {{`CALC_XLEN{1'b0}}, b};
  case (op)
    calc_pkg::e_calc_add: return a + b;
    calc_pkg::e_calc_sub: return a - b;
    calc_pkg::e_calc_and: return a & b;
    calc_pkg::e_calc_or:  return a | b;
    calc_pkg::e_calc_xor: return a ^ b;
    calc_pkg::e_calc_sll: return a << shamt;
    calc_pkg::e_calc_srl: return a >> shamt;
    calc_pkg::e_calc_slt: return ($signed(a) < $signed(b)) ? data_t'(1) : data_t'(0);
    // Low half of the full product
    calc_pkg::e_calc_mul: return wide[`CALC_XLEN-1:0];
    default:              return '0;
  endcase
endfunction

function automatic data_t read_arch(input reg_addr_t addr);
  return (addr == '0) ? '0 : arch_regs[addr];
endfunction

function automatic void retire(input calc_pkg::calc_dispatch_pkt_s pkt, input int cycle);
  data_t      a;
  data_t      b;
  wb_expect_s want;
  a = read_arch(pkt.rs1_addr);
  b = pkt.use_imm ? pkt.imm : read_arch(pkt.rs2_addr);
  want.cycle   = cycle + `CALC_COMP_DEPTH;
  want.rd_addr = pkt.rd_addr;
  want.rd_data = expected_result(pkt.op, a, b);
  if (pkt.rd_w_v)
  begin
    expect_q.push_back(want);
    if (pkt.rd_addr != '0)
    begin
      arch_regs[pkt.rd_addr] = want.rd_data;
    end
  end
endfunction

`endif

/* dv/tb_calc_top.sv */
//--------------------
// Calc core testbench
// Directed and random dispatch with flushes,
// checked against a program-order reference
//--------------------

`timescale 1ns/1ps

`include "calc_config.svh"

module tb_calc_top;

  `include "calc_ref.svh"

  localparam int num_instr_lp   = 400;
  localparam int directed_lp    = 19;
  localparam int start_cycle_lp = 10;
  localparam int use_regs_lp    = 8;

  logic                         clk = 1'b0;
  logic                         rst_n = 1'b0;
  logic                         flush = 1'b0;
  calc_pkg::calc_dispatch_pkt_s dispatch_pkt = '0;
  calc_pkg::calc_wb_pkt_s       iwb_pkt;

  calc_pkg::calc_dispatch_pkt_s prog [num_instr_lp];
  logic                         flush_prog [num_instr_lp];
  data_t                        rf [2**`CALC_REG_AW];
  integer                       seed = 32'h28d2db10;
  int unsigned                  cyc = 0;
  int                           checked = 0;
  int                           mismatches = 0;
  int                           other_errors = 0;

  calc_top UUT
  (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .dispatch_pkt_i (dispatch_pkt),
    .flush_i        (flush),
    .iwb_pkt_o      (iwb_pkt)
  );

  always #10 clk = ~clk;

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
  end

  function automatic int unsigned rand_below(input int unsigned k);
    int unsigned r;
    r = $unsigned($random(seed));
    return r % k;
  endfunction

  function automatic void set_instr
    (
      input int                 n,
      input calc_pkg::calc_op_e op,
      input int                 rd,
      input int                 rs1,
      input int                 rs2,
      input logic               use_imm,
      input data_t              imm
    );
    prog[n]          = '0;
    prog[n].v        = 1'b1;
    prog[n].op       = op;
    prog[n].rd_addr  = reg_addr_t'(rd);
    prog[n].rs1_addr = reg_addr_t'(rs1);
    prog[n].rs2_addr = reg_addr_t'(rs2);
    prog[n].rd_w_v   = 1'b1;
    prog[n].use_imm  = use_imm;
    prog[n].imm      = imm;
    // Junk operand values, replaced from the register file except for x0
    prog[n].rs1      = $random(seed);
    prog[n].rs2      = $random(seed);
  endfunction

  function automatic void build_program();
    int mul_ready [2**`CALC_REG_AW];
    for (int i = 0; i < 2**`CALC_REG_AW; i++)
    begin
      arch_regs[i] = (i == 0) ? '0 : $random(seed);
      rf[i]        = arch_regs[i];
      mul_ready[i] = 0;
    end
    for (int n = 0; n < num_instr_lp; n++)
    begin
      flush_prog[n] = 1'b0;
    end
    // Forwarding chains at distances 1 to 4, then multiply readers
    set_instr(0, calc_pkg::e_calc_add, 1, 0, 0, 1'b1, 32'd5);
    set_instr(1, calc_pkg::e_calc_add, 2, 1, 0, 1'b1, 32'd7);
    set_instr(2, calc_pkg::e_calc_sub, 3, 2, 1, 1'b0, 32'd0);
    set_instr(3, calc_pkg::e_calc_xor, 4, 3, 1, 1'b0, 32'd0);
    set_instr(4, calc_pkg::e_calc_or, 5, 4, 1, 1'b0, 32'd0);
    set_instr(5, calc_pkg::e_calc_mul, 6, 2, 3, 1'b0, 32'd0);
    set_instr(6, calc_pkg::e_calc_sll, 7, 5, 0, 1'b1, 32'd3);
    set_instr(7, calc_pkg::e_calc_srl, 1, 5, 2, 1'b0, 32'd0);
    set_instr(8, calc_pkg::e_calc_mul, 7, 6, 0, 1'b1, 32'd3);
    // x0 in flight must still read as zero
    set_instr(9, calc_pkg::e_calc_add, 0, 4, 0, 1'b1, 32'd9);
    set_instr(10, calc_pkg::e_calc_add, 2, 0, 0, 1'b0, 32'd0);
    set_instr(11, calc_pkg::e_calc_slt, 3, 1, 0, 1'b1, 32'hffff_ffff);
    set_instr(12, calc_pkg::e_calc_add, 5, 1, 1, 1'b0, 32'd0);
    prog[12].rd_w_v = 1'b0;
    // Flush in cycle of 16 kills 14 to 16, 13 survives
    set_instr(13, calc_pkg::e_calc_add, 1, 1, 0, 1'b1, 32'd1);
    set_instr(14, calc_pkg::e_calc_add, 2, 2, 0, 1'b1, 32'd1);
    set_instr(15, calc_pkg::e_calc_add, 3, 3, 0, 1'b1, 32'd1);
    set_instr(16, calc_pkg::e_calc_add, 4, 4, 0, 1'b1, 32'd1);
    flush_prog[16] = 1'b1;
    set_instr(17, calc_pkg::e_calc_add, 5, 2, 3, 1'b0, 32'd0);
    set_instr(18, calc_pkg::e_calc_add, 6, 4, 1, 1'b0, 32'd0);
    for (int n = directed_lp; n < num_instr_lp; n++)
    begin
      set_instr(n, calc_pkg::calc_op_e'(rand_below(9)), int'(rand_below(use_regs_lp)),
                int'(rand_below(use_regs_lp)), int'(rand_below(use_regs_lp)),
                rand_below(2) == 1, $random(seed));
      prog[n].v      = (rand_below(10) != 0);
      prog[n].poison = (rand_below(25) == 0);
      prog[n].rd_w_v = (rand_below(8) != 0);
      flush_prog[n]  = (rand_below(30) == 0);
      // Product is readable three cycles after the multiply
      if (mul_ready[prog[n].rs1_addr] > n)
      begin
        prog[n].rs1_addr = '0;
      end
      if (mul_ready[prog[n].rs2_addr] > n)
      begin
        prog[n].rs2_addr = '0;
      end
      if (prog[n].v && prog[n].rd_w_v && (prog[n].op == calc_pkg::e_calc_mul))
      begin
        mul_ready[prog[n].rd_addr] = n + 3;
      end
    end
  endfunction

  function automatic void predict_writebacks();
    logic killed;
    for (int n = 0; n < num_instr_lp; n++)
    begin
      killed = prog[n].poison | flush_prog[n];
      if (n + 1 < num_instr_lp)
      begin
        killed = killed | flush_prog[n+1];
      end
      if (n + 2 < num_instr_lp)
      begin
        killed = killed | flush_prog[n+2];
      end
      if (prog[n].v && !killed)
      begin
        retire(prog[n], start_cycle_lp + n);
      end
    end
  endfunction

  // Issue stage: commit the writeback, then read operands for the next cycle
  always @(posedge clk)
  begin
    calc_pkg::calc_dispatch_pkt_s pkt;
    int                           n;
    if ((iwb_pkt.w_v === 1'b1) && (iwb_pkt.rd_addr != '0))
    begin
      rf[iwb_pkt.rd_addr] = iwb_pkt.rd_data;
    end
    rst_n <= (cyc >= 7);
    n = int'(cyc) + 1 - start_cycle_lp;
    if ((n >= 0) && (n < num_instr_lp))
    begin
      pkt = prog[n];
      if (pkt.rs1_addr != '0)
      begin
        pkt.rs1 = rf[pkt.rs1_addr];
      end
      if (pkt.rs2_addr != '0)
      begin
        pkt.rs2 = rf[pkt.rs2_addr];
      end
      dispatch_pkt <= pkt;
      flush        <= flush_prog[n];
    end
    else
    begin
      dispatch_pkt <= '0;
      flush        <= 1'b0;
    end
  end

  always @(posedge clk)
  begin
    wb_expect_s want;
    if (cyc >= 1)
    begin
      if (iwb_pkt.w_v === 1'b1)
      begin
        checked++;
        if (expect_q.size() == 0)
        begin
          $display("Unexpected writeback to x%0d at %0t", iwb_pkt.rd_addr, $time);
          other_errors++;
        end
        else
        begin
          want = expect_q.pop_front();
          if ((want.cycle != cyc) || (want.rd_addr !== iwb_pkt.rd_addr)
              || (want.rd_data !== iwb_pkt.rd_data))
          begin
            $display("MISMATCH at %0t: cycle %0d x%0d = %h, expected cycle %0d x%0d = %h",
                     $time, cyc, iwb_pkt.rd_addr, iwb_pkt.rd_data,
                     want.cycle, want.rd_addr, want.rd_data);
            mismatches++;
          end
        end
      end
      else if (iwb_pkt.w_v !== 1'b0)
      begin
        $display("Writeback valid is unknown at %0t", $time);
        other_errors++;
      end
      else if ((expect_q.size() != 0) && (expect_q[0].cycle <= cyc))
      begin
        want = expect_q.pop_front();
        $display("MISMATCH at %0t: missing writeback of x%0d = %h due in cycle %0d",
                 $time, want.rd_addr, want.rd_data, want.cycle);
        mismatches++;
      end
    end
  end

  initial
  begin
    int last_cycle;
    build_program();
    predict_writebacks();
    last_cycle = start_cycle_lp + num_instr_lp + `CALC_COMP_DEPTH + 2;
    while ((expect_q.size() != 0) || (cyc < last_cycle))
    begin
      @(negedge clk);
    end
    if (checked == 0)
    begin
      $display("No writebacks were seen");
      other_errors++;
    end
    $display("Errors: %0d mismatches, %0d other, %0d writebacks checked",
             mismatches, other_errors, checked);
    if ((mismatches == 0) && (other_errors == 0))
    begin
      $display("SIMULATION PASSED");
    end
    else
    begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial
  begin
    repeat (num_instr_lp * 10 + 100) @(posedge clk);
    $display("Timeout: run did not finish, %0d writebacks still pending", expect_q.size());
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* rtl/calc_alu.sv */
//------------------
// Calc ALU
// Single-cycle integer unit for all
// non-multiply operations
//------------------

`timescale 1ns/1ps

`include "calc_config.svh"

module calc_alu
  (
    input  calc_pkg::calc_dispatch_pkt_s  reservation_i,
    output logic [`CALC_XLEN-1:0]         data_o,
    output logic                          v_o
  );

  logic [`CALC_XLEN-1:0] op1;
  logic [`CALC_XLEN-1:0] op2;
  logic [4:0]            shamt;

  assign op1   = reservation_i.rs1;
  assign op2   = reservation_i.use_imm ? reservation_i.imm : reservation_i.rs2;
  assign shamt = op2[4:0];

  always_comb
  begin
    case (reservation_i.op)
      calc_pkg::e_calc_add: data_o = op1 + op2;
      calc_pkg::e_calc_sub: data_o = op1 - op2;
      calc_pkg::e_calc_and: data_o = op1 & op2;
      calc_pkg::e_calc_or:  data_o = op1 | op2;
      calc_pkg::e_calc_xor: data_o = op1 ^ op2;
      calc_pkg::e_calc_sll: data_o = op1 << shamt;
      calc_pkg::e_calc_srl: data_o = op1 >> shamt;
      // Signed compare
      calc_pkg::e_calc_slt: data_o = {{(`CALC_XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
      default:              data_o = '0;
    endcase
  end

  assign v_o = reservation_i.v & (reservation_i.op != calc_pkg::e_calc_mul);

endmodule

/* rtl/calc_comp_pipe.sv */
//------------------
// Calc completion pipe
// Carries write intent down to the integer
// writeback, merges results from the pipes,
// kills flushed work and feeds the bypass
//------------------

`timescale 1ns/1ps

`include "calc_config.svh"

module calc_comp_pipe
  (
    input  logic                                        clk_i,
    input  logic                                        rst_n_i,
    input  calc_pkg::calc_dispatch_pkt_s                dispatch_pkt_i,
    input  logic                                        flush_i,
    input  logic [`CALC_XLEN-1:0]                       alu_data_i,
    input  logic                                        alu_v_i,
    input  logic [`CALC_XLEN-1:0]                       mul_data_i,
    input  logic                                        mul_v_i,
    output calc_pkg::calc_fwd_s [`CALC_COMP_DEPTH-1:0]  fwd_o,
    output calc_pkg::calc_wb_pkt_s                      iwb_pkt_o
  );

  localparam int depth_lp     = `CALC_COMP_DEPTH;
  localparam int alu_stage_lp = 1;
  localparam int mul_stage_lp = `CALC_MUL_LATENCY;
  // Stages still killable by a flush
  localparam int kill_els_lp  = 3;

  calc_pkg::calc_wb_pkt_s [depth_lp:0]    comp_stage_n;
  calc_pkg::calc_wb_pkt_s [depth_lp-1:0]  comp_stage_r;
  logic [kill_els_lp-1:0]                 poison_n;
  logic [kill_els_lp-2:0]                 poison_r;

  always_comb
  begin
    poison_n[0] = dispatch_pkt_i.poison | flush_i;
    for (int i = 1; i < kill_els_lp; i++)
    begin
      poison_n[i] = poison_r[i-1] | flush_i;
    end
  end

  always_comb
  begin
    comp_stage_n[0].w_v     = dispatch_pkt_i.v & dispatch_pkt_i.rd_w_v;
    comp_stage_n[0].rd_addr = dispatch_pkt_i.rd_addr;
    comp_stage_n[0].rd_data = '0;
    for (int i = 1; i <= depth_lp; i++)
    begin
      comp_stage_n[i] = comp_stage_r[i-1];
    end

    // Static latencies, so at most one pipe finishes per stage
    if (alu_v_i)
    begin
      comp_stage_n[alu_stage_lp].rd_data = alu_data_i;
    end
    if (mul_v_i)
    begin
      comp_stage_n[mul_stage_lp].rd_data = mul_data_i;
    end

    for (int i = 0; i < kill_els_lp; i++)
    begin
      comp_stage_n[i].w_v = comp_stage_n[i].w_v & ~poison_n[i];
    end
  end

  always_ff @(posedge clk_i)
  begin
    comp_stage_r <= comp_stage_n[depth_lp-1:0];
    if (!rst_n_i)
    begin
      poison_r <= '0;
      for (int i = 0; i < depth_lp; i++)
      begin
        comp_stage_r[i].w_v <= 1'b0;
      end
    end
    else
    begin
      poison_r <= poison_n[kill_els_lp-2:0];
    end
  end

  // Next-state view, so a result is visible in the cycle it is produced
  always_comb
  begin
    for (int i = 1; i <= depth_lp; i++)
    begin
      fwd_o[i-1].v       = comp_stage_n[i].w_v;
      fwd_o[i-1].rd_addr = comp_stage_n[i].rd_addr;
      fwd_o[i-1].rd_data = comp_stage_n[i].rd_data;
    end
  end

  assign iwb_pkt_o = comp_stage_r[depth_lp-1];

endmodule

/* rtl/calc_config.svh */
//------------------
// Calc config
// Sizing of the integer execution core
//------------------

`ifndef CALC_CONFIG_SVH
`define CALC_CONFIG_SVH

// Data path and register file
`define CALC_XLEN 32
`define CALC_REG_AW 5

// Completion registers between reservation and writeback
`define CALC_COMP_DEPTH 4

// Reservation register to multiply result, in cycles
`define CALC_MUL_LATENCY 3

`endif

/* rtl/calc_pipe_mul.sv */
//------------------
// Calc multiply pipe
// Pipelined integer multiply, low half
// of the product
//------------------

`timescale 1ns/1ps

`include "calc_config.svh"

module calc_pipe_mul
  (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  calc_pkg::calc_dispatch_pkt_s  reservation_i,
    output logic [`CALC_XLEN-1:0]         data_o,
    output logic                          v_o
  );

  // Reservation register counts as the first cycle
  localparam int stages_lp = `CALC_MUL_LATENCY - 1;

  logic [`CALC_XLEN-1:0]                  op2;
  logic [`CALC_XLEN-1:0]                  product;
  logic                                   v_n;
  logic [stages_lp-1:0][`CALC_XLEN-1:0]   data_r;
  logic [stages_lp-1:0]                   v_r;

  assign op2     = reservation_i.use_imm ? reservation_i.imm : reservation_i.rs2;
  assign product = reservation_i.rs1 * op2;
  assign v_n     = reservation_i.v & ~reservation_i.poison
                   & (reservation_i.op == calc_pkg::e_calc_mul);

  always_ff @(posedge clk_i)
  begin
    data_r[0] <= product;
    for (int i = 1; i < stages_lp; i++)
    begin
      data_r[i] <= data_r[i-1];
    end
  end

  // One bit per multiply in flight
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      v_r <= '0;
    end
    else
    begin
      v_r[0] <= v_n;
      for (int i = 1; i < stages_lp; i++)
      begin
        v_r[i] <= v_r[i-1];
      end
    end
  end

  assign data_o = data_r[stages_lp-1];
  assign v_o    = v_r[stages_lp-1];

endmodule

/* rtl/calc_pkg.sv */
//------------------
// Calc package
// Operation codes and the packets that move
// through the execution core
//------------------

`include "calc_config.svh"

package calc_pkg;

  typedef enum logic [3:0]
  {
    e_calc_add = 4'd0,
    e_calc_sub = 4'd1,
    e_calc_and = 4'd2,
    e_calc_or  = 4'd3,
    e_calc_xor = 4'd4,
    e_calc_sll = 4'd5,
    e_calc_srl = 4'd6,
    e_calc_slt = 4'd7,
    e_calc_mul = 4'd8
  } calc_op_e;

  // Issued instruction, rs1/rs2 as read from the register file
  typedef struct packed
  {
    logic                    v;
    logic                    poison;
    calc_op_e                op;
    logic [`CALC_REG_AW-1:0] rs1_addr;
    logic [`CALC_REG_AW-1:0] rs2_addr;
    logic [`CALC_REG_AW-1:0] rd_addr;
    logic                    rd_w_v;
    logic                    use_imm;
    logic [`CALC_XLEN-1:0]   rs1;
    logic [`CALC_XLEN-1:0]   rs2;
    logic [`CALC_XLEN-1:0]   imm;
  } calc_dispatch_pkt_s;

  typedef struct packed
  {
    logic                    w_v;
    logic [`CALC_REG_AW-1:0] rd_addr;
    logic [`CALC_XLEN-1:0]   rd_data;
  } calc_wb_pkt_s;

  typedef struct packed
  {
    logic                    v;
    logic [`CALC_REG_AW-1:0] rd_addr;
    logic [`CALC_XLEN-1:0]   rd_data;
  } calc_fwd_s;

endpackage

/* rtl/calc_reservation.sv */
//------------------
// Calc reservation
// Operand bypass from the completion pipe
// and the reservation register feeding
// the execution pipes
//------------------

`timescale 1ns/1ps

`include "calc_config.svh"

module calc_reservation
  (
    input  logic                                           clk_i,
    input  calc_pkg::calc_dispatch_pkt_s                   dispatch_pkt_i,
    input  logic                                           flush_i,
    input  calc_pkg::calc_fwd_s [`CALC_COMP_DEPTH-1:0]     fwd_i,
    output calc_pkg::calc_dispatch_pkt_s                   reservation_o
  );

  calc_pkg::calc_dispatch_pkt_s reservation_n;
  calc_pkg::calc_dispatch_pkt_s reservation_r;

  // Slot 0 is the youngest, so it is checked last and wins
  function automatic logic [`CALC_XLEN-1:0] bypass
    (
      input logic [`CALC_REG_AW-1:0]                     addr,
      input logic [`CALC_XLEN-1:0]                       rf_data,
      input calc_pkg::calc_fwd_s [`CALC_COMP_DEPTH-1:0]  fwd
    );
    logic [`CALC_XLEN-1:0] data;
    data = rf_data;
    for (int i = `CALC_COMP_DEPTH-1; i >= 0; i--)
    begin
      if (fwd[i].v && (fwd[i].rd_addr == addr))
      begin
        data = fwd[i].rd_data;
      end
    end
    // x0 is hardwired
    if (addr == '0)
    begin
      data = '0;
    end
    return data;
  endfunction

  always_comb
  begin
    reservation_n        = dispatch_pkt_i;
    reservation_n.poison = dispatch_pkt_i.poison | flush_i;
    reservation_n.rs1    = bypass(dispatch_pkt_i.rs1_addr, dispatch_pkt_i.rs1, fwd_i);
    reservation_n.rs2    = bypass(dispatch_pkt_i.rs2_addr, dispatch_pkt_i.rs2, fwd_i);
  end

  always_ff @(posedge clk_i)
  begin
    reservation_r <= reservation_n;
  end

  assign reservation_o = reservation_r;

endmodule

/* rtl/calc_top.sv */
//------------------
// Calc top
// Integer execution core: bypass and
// reservation, ALU, multiplier and the
// completion pipe to writeback
//------------------

`timescale 1ns/1ps

`include "calc_config.svh"

module calc_top
  (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  calc_pkg::calc_dispatch_pkt_s  dispatch_pkt_i,
    input  logic                          flush_i,
    output calc_pkg::calc_wb_pkt_s        iwb_pkt_o
  );

  calc_pkg::calc_dispatch_pkt_s                reservation;
  calc_pkg::calc_fwd_s [`CALC_COMP_DEPTH-1:0]  fwd;
  logic [`CALC_XLEN-1:0]                       alu_data;
  logic                                        alu_v;
  logic [`CALC_XLEN-1:0]                       mul_data;
  logic                                        mul_v;

  calc_reservation u_reservation
  (
    .clk_i          (clk_i),
    .dispatch_pkt_i (dispatch_pkt_i),
    .flush_i        (flush_i),
    .fwd_i          (fwd),
    .reservation_o  (reservation)
  );

  calc_alu u_alu
  (
    .reservation_i (reservation),
    .data_o        (alu_data),
    .v_o           (alu_v)
  );

  calc_pipe_mul u_pipe_mul
  (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .reservation_i (reservation),
    .data_o        (mul_data),
    .v_o           (mul_v)
  );

  // Stage 0 starts from the raw dispatch packet
  calc_comp_pipe u_comp_pipe
  (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .dispatch_pkt_i (dispatch_pkt_i),
    .flush_i        (flush_i),
    .alu_data_i     (alu_data),
    .alu_v_i        (alu_v),
    .mul_data_i     (mul_data),
    .mul_v_i        (mul_v),
    .fwd_o          (fwd),
    .iwb_pkt_o      (iwb_pkt_o)
  );

endmodule

/* vlog.f */
+incdir+rtl
+incdir+dv
rtl/calc_pkg.sv
rtl/calc_reservation.sv
rtl/calc_alu.sv
rtl/calc_pipe_mul.sv
rtl/calc_comp_pipe.sv
rtl/calc_top.sv
dv/tb_calc_top.sv
